// File: Bender.yml
package:
  name: decode_stage

sources:
  - logic/decodePkg.sv
  - logic/regFileIf.sv
  - logic/regFile.sv
  - logic/decodeCtrl.sv
  - logic/branchResolve.sv
  - logic/decodeStage.sv
  - target: test
    files:
      - tests/decodeStageTb.sv

// File: filelist.f
logic/decodePkg.sv
logic/regFileIf.sv
logic/regFile.sv
logic/decodeCtrl.sv
logic/branchResolve.sv
logic/decodeStage.sv
tests/decodeStageTb.sv

// File: logic/branchResolve.sv
//==========================================================================
// branch condition check and pc select, purely combinational
// condition is tested on the first source operand only
// halt suppresses pcSel, jFlag forces it for any branch-class instr
// target address is computed elsewhere, this only gives the select
//==========================================================================
`timescale 1ns/10ps

module branchResolve (
   input  decodePkg::word_t instr,
   input  decodePkg::word_t operand,   // rs read data
   input  logic             bFlag,     // branch strobe from control
   input  logic             jFlag,     // jump strobe
   input  logic             halt,
   output logic             pcSel      // 1 = take branch/jump target
);
   import decodePkg::*;

   brCond_t cond;
   logic    isBranch;
   logic    operandZero;
   logic    operandNeg;
   logic    condMet;

   assign cond = instr[12:11];

   // 011xx opcodes, or control says so
   assign isBranch = (instr[15:13] == OP_BRANCH_PREFIX) || bFlag;

   // flags off the operand
   assign operandZero = (operand == '0);      // plain zero test
   assign operandNeg  = operand[WORD_W-1];    // sign bit

   always_comb begin
      unique case (cond)
         COND_EQZ: condMet = operandZero;     // beqz
         COND_NEZ: condMet = !operandZero;    // bnez
         COND_LTZ: condMet = operandNeg;      // bltz
         COND_GEZ: condMet = !operandNeg;     // bgez
      endcase
   end

   // jump strobe overrides the condition, halt blocks any redirect
   assign pcSel = isBranch && !halt && (condMet || jFlag);

endmodule

// File: logic/decodeCtrl.sv
//==========================================================================
// decode control, purely combinational
// pulls rs/rt out of the instruction, forces r7 as rs for 0011x ops
// picks register write data, link beats lbi beats writeback
// write address and enable pass straight through from later stages
// no immediate extension here, imm arrives already formed
//==========================================================================
`timescale 1ns/10ps

module decodeCtrl (
   input  decodePkg::word_t    instr,
   input  decodePkg::word_t    imm,           // load-immediate value
   input  decodePkg::word_t    pc,            // pc of this instr
   input  decodePkg::word_t    writeback,     // result from wb stage
   input  decodePkg::regAddr_t writeRegAddr,
   input  logic                lbi,
   input  logic                link,
   input  logic                en,            // write enable
   regFileIf.ctrl              rf
);
   import decodePkg::*;

   opcode_t opcode;
   logic    linkOp;     // opcode 0011x
   regAddr_t rsField;
   regAddr_t rtField;
   word_t   pcPlus2;
   word_t   immSel;

   // instruction fields
   assign opcode  = instr[15:11];
   assign rsField = instr[10:8];
   assign rtField = instr[7:5];

   // jal/jalr style ops read the link register as first source
   assign linkOp = (opcode[4:1] == OP_LINK_PREFIX);

   always_comb begin
      if (linkOp) begin
         rf.readAddr1 = LINK_REG;
      end else begin
         rf.readAddr1 = rsField;
      end
   end

   assign rf.readAddr2 = rtField;

   // return address for link writes, carry out dropped
   assign pcPlus2 = pc + PC_STEP;

   // lbi vs writeback first
   assign immSel = lbi ? imm : writeback;

   // link has top priority regardless of lbi
   always_comb begin
      if (link) begin
         rf.writeData = pcPlus2;
      end else begin
         rf.writeData = immSel;
      end
   end

   // write target and strobe from later stages
   assign rf.writeAddr = writeRegAddr;
   assign rf.writeEn   = en;   // low during a stall, regs hold

endmodule

// File: logic/decodePkg.sv
//==========================================================================
// shared types and instruction-set constants for the decode stage
// word width and register count are fixed by the ISA, not tunable
// opcode lives in instr[15:11], branch condition in instr[12:11]
//==========================================================================

package decodePkg;

   // widths
   localparam int WORD_W    = 16;
   localparam int REG_AW    = 3;
   localparam int OPCODE_W  = 5;
   localparam int BRCOND_W  = 2;

   localparam int NUM_REGS  = 8;        // r0..r7

   typedef logic [WORD_W-1:0]   word_t;     // data, pc, imm, instr
   typedef logic [REG_AW-1:0]   regAddr_t;
   typedef logic [OPCODE_W-1:0] opcode_t;   // instr[15:11]
   typedef logic [BRCOND_W-1:0] brCond_t;   // instr[12:11]

   // link register, forced as first source for jal/jalr style ops
   localparam regAddr_t LINK_REG = regAddr_t'(7);

   // next sequential pc for link write data
   localparam word_t PC_STEP = word_t'(2);

   // opcode prefixes
   localparam logic [3:0] OP_LINK_PREFIX   = 4'b0011;  // 0011x
   localparam logic [2:0] OP_BRANCH_PREFIX = 3'b011;   // 011xx

   // branch conditions, tested on first source operand
   localparam brCond_t COND_EQZ = brCond_t'(0);  // rs == 0
   localparam brCond_t COND_NEZ = brCond_t'(1);  // rs != 0
   localparam brCond_t COND_LTZ = brCond_t'(2);  // rs < 0
   localparam brCond_t COND_GEZ = brCond_t'(3);  // rs >= 0

endpackage

// File: logic/decodeStage.sv
//==========================================================================
// decode stage top level
// register file plus source/write-data control plus branch resolve
// reads and pcSel are combinational, writes land on the rising clk edge
// nothing at this level is registered, no handshakes
// after reset every register reads zero
//==========================================================================
`timescale 1ns/10ps

module decodeStage (
   input  logic                clk,
   input  logic                rstN,
   input  decodePkg::word_t    instr,          // from fetch
   input  decodePkg::word_t    imm,
   input  decodePkg::word_t    pc,             // from fetch
   input  decodePkg::word_t    writeback,
   input  decodePkg::regAddr_t writeRegAddr,   // from wb stage
   input  logic                lbi,
   input  logic                link,
   input  logic                en,
   input  logic                bFlag,
   input  logic                jFlag,
   input  logic                halt,
   output decodePkg::word_t    reg1Data,       // rs or r7
   output decodePkg::word_t    reg2Data,       // rt
   output logic                pcSel
);

   // internal register file bus
   regFileIf rfBus (.clk(clk));

   // field extraction and write-data mux
   decodeCtrl uCtrl (
      .instr        (instr),
      .imm          (imm),
      .pc           (pc),
      .writeback    (writeback),
      .writeRegAddr (writeRegAddr),
      .lbi          (lbi),
      .link         (link),
      .en           (en),
      .rf           (rfBus.ctrl)
   );

   // storage
   regFile uRegFile (
      .clk  (clk),
      .rstN (rstN),
      .rf   (rfBus.store)
   );

   // branch decision on first source operand
   branchResolve uBranch (
      .instr   (instr),
      .operand (rfBus.readData1),
      .bFlag   (bFlag),
      .jFlag   (jFlag),
      .halt    (halt),
      .pcSel   (pcSel)
   );

   // operands out to execute
   assign reg1Data = rfBus.readData1;
   assign reg2Data = rfBus.readData2;

endmodule

// File: logic/regFile.sv
//==========================================================================
// eight 16-bit registers, two combinational reads, one clocked write
// all entries clear asynchronously while rstN is low
// a write in flight is forwarded to any read of the same address
// r0 is an ordinary register, not hardwired to zero
//==========================================================================
`timescale 1ns/10ps

module regFile (
   input  logic     clk,
   input  logic     rstN,
   regFileIf.store  rf
);
   import decodePkg::*;

   word_t regs [NUM_REGS];   // register array

   // write port
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         regs <= '{default: '0};
      end else if (rf.writeEn) begin
         regs[rf.writeAddr] <= rf.writeData;
      end
   end

   // read port 1, with bypass
   always_comb begin
      rf.readData1 = regs[rf.readAddr1];
      if (rf.writeEn && (rf.writeAddr == rf.readAddr1)) begin
         rf.readData1 = rf.writeData;   // same-cycle write wins
      end
   end

   // read port 2, same bypass
   always_comb begin
      rf.readData2 = regs[rf.readAddr2];
      if (rf.writeEn && (rf.writeAddr == rf.readAddr2)) begin
         rf.readData2 = rf.writeData;
      end
   end

   // write address comes from later stages through decodeCtrl,
   // an X there would corrupt an unknown entry
   writeAddrKnown: assert property (
      @(posedge rf.clk) disable iff (!rstN)
      rf.writeEn |-> !$isunknown(rf.writeAddr)
   ) else $error("regFile write with unknown address %b", rf.writeAddr);

   // untouched entries hold across the edge
   for (genvar i = 0; i < NUM_REGS; i++) begin : gHold
      regHeld: assert property (
         @(posedge rf.clk) disable iff (!rstN)
         !(rf.writeEn && (rf.writeAddr == regAddr_t'(i))) |=> $stable(regs[i])
      ) else $error("regFile entry %0d changed without a write", i);
   end

endmodule

// File: logic/regFileIf.sv
//==========================================================================
// register file bus between decode control and storage
// ctrl side drives addresses and write controls, store side returns data
// no handshake, all signals are plain levels
//==========================================================================
`timescale 1ns/10ps

interface regFileIf (input logic clk);
   import decodePkg::*;

   regAddr_t readAddr1;   // rs, or link reg
   regAddr_t readAddr2;   // rt
   word_t    readData1;
   word_t    readData2;
   regAddr_t writeAddr;
   word_t    writeData;
   logic     writeEn;

   // decode side
   modport ctrl (
      output readAddr1, readAddr2, writeAddr, writeData, writeEn,
      input  readData1, readData2
   );

   // storage side, clk kept for its checks
   modport store (
      input  clk,
      input  readAddr1, readAddr2, writeAddr, writeData, writeEn,
      output readData1, readData2
   );

endinterface

// File: tests/decodeStageTb.sv
//==========================================================================
// testbench for the decode stage top level
// inputs change on the falling edge, outputs compared 10 ns before rising
// shadow copy of the register file built from the write rules alone
// random phase uses a 16-bit Galois LFSR, one step per bit taken
// first mismatch ends the run
//==========================================================================
`timescale 1ns/10ps

module decodeStageTb;
   import decodePkg::*;

   localparam int RESET_CYCLES    = 2;
   localparam int DIRECTED_CYCLES = 16;
   localparam int RANDOM_CYCLES   = 500;
   localparam int MARGIN_CYCLES   = 182;
   localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                    + MARGIN_CYCLES;   // 700

   logic     clk;
   logic     rstN;
   word_t    instr;
   word_t    imm;
   word_t    pc;
   word_t    writeback;
   regAddr_t writeRegAddr;
   logic     lbi;
   logic     link;
   logic     en;
   logic     bFlag;
   logic     jFlag;
   logic     halt;
   word_t    reg1Data;
   word_t    reg2Data;
   logic     pcSel;

   word_t       shadow [8];       // expected register contents
   logic [15:0] lfsrState = 16'd6829;
   int          cycleCount = 0;

   decodeStage u_dut (
      .clk          (clk),
      .rstN         (rstN),
      .instr        (instr),
      .imm          (imm),
      .pc           (pc),
      .writeback    (writeback),
      .writeRegAddr (writeRegAddr),
      .lbi          (lbi),
      .link         (link),
      .en           (en),
      .bFlag        (bFlag),
      .jFlag        (jFlag),
      .halt         (halt),
      .reg1Data     (reg1Data),
      .reg2Data     (reg2Data),
      .pcSel        (pcSel)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   // reference model
   function automatic regAddr_t refRs(input word_t i);
      if (i[15:12] == 4'b0011) return 3'd7;   // link ops read r7
      return i[10:8];
   endfunction

   function automatic regAddr_t refRt(input word_t i);
      return i[7:5];
   endfunction

   function automatic word_t refWriteData(input word_t p, input word_t im, input word_t wb,
                                          input logic useImm, input logic useLink);
      if (useLink) return p + 16'd2;   // link first
      if (useImm) return im;
      return wb;
   endfunction

   // read as seen this cycle, pending write shows through
   function automatic word_t refRead(input regAddr_t a);
      if (en && (writeRegAddr == a)) return refWriteData(pc, imm, writeback, lbi, link);
      return shadow[a];
   endfunction

   function automatic logic refPcSel(input word_t i, input word_t op, input logic b,
                                     input logic j, input logic h);
      logic branchy;
      logic taken;
      branchy = (i[15:13] == 3'b011) || b;
      case (i[12:11])
         2'd0:    taken = (op == 16'h0000);
         2'd1:    taken = (op != 16'h0000);
         2'd2:    taken = ($signed(op) < 0);
         default: taken = ($signed(op) >= 0);
      endcase
      return branchy && !h && (taken || j);
   endfunction

   // shadow follows every enabled write
   always @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int k = 0; k < 8; k++) shadow[k] <= '0;
      end else if (en) begin
         shadow[writeRegAddr] <= refWriteData(pc, imm, writeback, lbi, link);
      end
   end

   // checks
   task automatic checkWord(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "decode stage output mismatch");
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "decode stage output mismatch");
      end
   endtask

   always @(negedge clk) begin : sampleAndCompare
      word_t expR1;
      word_t expR2;
      #40;   // 10 ns before the rising edge
      if (rstN) begin
         expR1 = refRead(refRs(instr));
         expR2 = refRead(refRt(instr));
         checkWord("reg1Data", reg1Data, expR1);
         checkWord("reg2Data", reg2Data, expR2);
         checkBit("pcSel", pcSel, refPcSel(instr, expR1, bFlag, jFlag, halt));
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // stimulus helpers
   function automatic logic [15:0] lfsrStep(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 16'hB400;   // taps 16,14,13,11
      return n;
   endfunction

   task automatic randBits(input int n, output word_t v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsrState = lfsrStep(lfsrState);
         v = {v[14:0], lfsrState[0]};
      end
   endtask

   function automatic word_t mkInstr(input opcode_t op, input regAddr_t rs, input regAddr_t rt);
      return {op, rs, rt, 5'b00000};
   endfunction

   task automatic setIdle();
      instr        = '0;
      imm          = '0;
      pc           = '0;
      writeback    = '0;
      writeRegAddr = '0;
      lbi          = 1'b0;
      link         = 1'b0;
      en           = 1'b0;
      bFlag        = 1'b0;
      jFlag        = 1'b0;
      halt         = 1'b0;
   endtask

   task automatic nextCycle();
      @(negedge clk);
      setIdle();   // caller overrides what it needs
   endtask

   task automatic writeReg(input regAddr_t a, input word_t v, input word_t i);
      nextCycle();
      en           = 1'b1;
      writeRegAddr = a;
      writeback    = v;
      instr        = i;
   endtask

   // directed phases
   task automatic resetReads();
      for (int k = 0; k < 4; k++) begin
         nextCycle();
         instr = mkInstr(opcode_t'(k), regAddr_t'(2 * k), regAddr_t'(2 * k + 1));
      end
   endtask

   task automatic writeAndReadBack();
      writeReg(3'd1, 16'h1234, mkInstr(5'b00000, 3'd0, 3'd0));
      writeReg(3'd2, 16'hBEEF, mkInstr(5'b00000, 3'd1, 3'd3));   // r1 stored, r3 zero
      nextCycle();
      instr = mkInstr(5'b00000, 3'd2, 3'd1);
      nextCycle();
      instr = mkInstr(5'b00000, 3'd0, 3'd5);   // untouched regs
   endtask

   task automatic writeDataPriority();
      nextCycle();
      en           = 1'b1;
      writeRegAddr = 3'd3;
      link         = 1'b1;
      lbi          = 1'b1;      // link must win
      imm          = 16'h5555;
      pc           = 16'h0100;
      nextCycle();
      en           = 1'b1;
      writeRegAddr = 3'd4;
      lbi          = 1'b1;
      imm          = 16'h00A5;
      writeback    = 16'hFFFF;
      nextCycle();
      instr = mkInstr(5'b00000, 3'd3, 3'd4);
   endtask

   task automatic forwardedReads();
      writeReg(3'd5, 16'h8001, mkInstr(5'b00000, 3'd5, 3'd5));   // both ports bypass
      writeReg(3'd6, 16'h7777, mkInstr(5'b00000, 3'd5, 3'd6));   // rt only
   endtask

   task automatic linkOverride();
      writeReg(3'd7, 16'hC0DE, mkInstr(5'b00000, 3'd0, 3'd0));
      nextCycle();
      instr = mkInstr(5'b00110, 3'd1, 3'd2);
      nextCycle();
      instr = mkInstr(5'b00111, 3'd4, 3'd7);
   endtask

   task automatic randomCycles();
      word_t v;
      for (int n = 0; n < RANDOM_CYCLES; n++) begin
         nextCycle();
         randBits(16, v);
         instr = v;
         randBits(1, v);
         if (v[0]) instr[15:13] = 3'b011;   // lean toward branch opcodes
         randBits(16, v);
         imm = v;
         randBits(16, v);
         pc = v;
         randBits(2, v);
         if (v[1:0] == 2'b00) begin
            writeback = '0;                  // zero operands now and then
         end else begin
            randBits(16, v);
            writeback = v;
         end
         randBits(3, v);
         writeRegAddr = v[2:0];
         randBits(1, v);
         lbi = v[0];
         randBits(2, v);
         link = &v[1:0];
         randBits(1, v);
         en = v[0];
         randBits(1, v);
         bFlag = v[0];
         randBits(1, v);
         jFlag = v[0];
         randBits(2, v);
         halt = &v[1:0];
      end
   endtask

   initial begin
      setIdle();
      rstN = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      resetReads();
      writeAndReadBack();
      writeDataPriority();
      forwardedReads();
      linkOverride();
      randomCycles();
      @(posedge clk);   // last compare lands just before this edge
      $display("TEST PASSED");
      $finish;
   end

endmodule
